//--- logic/hdc_dim_pkg.sv
`default_nettype none

package hdc_dim_pkg;

    // hypervector geometry
    localparam int DIM       = 64;
    // one lane per core result
    localparam int NUM_LANES = 4;

    // signed per-dimension counter
    localparam int CNT_W     = 8;
    // symmetric limits, so -128 is never reached
    localparam int CNT_MAX   = 2 ** (CNT_W - 1) - 1;
    localparam int CNT_MIN   = -CNT_MAX;
    // room for counter plus up to NUM_LANES steps before clamping
    localparam int SUM_W     = CNT_W + 2;

    // number of vectors added since clear, wraps
    localparam int TALLY_W   = 16;

    typedef logic [DIM-1:0]            hv_t;
    typedef logic signed [CNT_W-1:0]   count_t;
    typedef logic signed [SUM_W-1:0]   sum_t;
    typedef logic [TALLY_W-1:0]        tally_t;

endpackage

`default_nettype wire

//--- logic/hdc_cmd_pkg.sv
`default_nettype none

package hdc_cmd_pkg;

    import hdc_dim_pkg::*;

    // command opcodes
    typedef enum logic [1:0] {
        op_clear           = 2'd0,
        op_accumulate      = 2'd1,
        op_bind_accumulate = 2'd2,
        op_read            = 2'd3
    } opcode_t;

    // command as it arrives from the cores
    typedef struct packed {
        opcode_t                opcode;
        logic [NUM_LANES-1:0]   lane_mask;
        hv_t                    key;
        hv_t [NUM_LANES-1:0]    lanes;
    } hdc_cmd_t;

    // decoded op, key already applied to the lanes
    // lane_mask is zero for clear and read
    typedef struct packed {
        opcode_t                opcode;
        logic [NUM_LANES-1:0]   lane_mask;
        hv_t [NUM_LANES-1:0]    lanes;
    } hdc_op_t;

    // read result
    typedef struct packed {
        hv_t      sign;
        tally_t   tally;
    } hdc_result_t;

endpackage

`default_nettype wire

//--- logic/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
    import hdc_dim_pkg::*, hdc_cmd_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,

    // command side
    input  wire logic   cmd_valid,
    output logic        cmd_ready,
    input  hdc_cmd_t    cmd,

    // towards the counters
    output logic        op_valid,
    input  wire logic   op_ready,
    output hdc_op_t     op
);

    hdc_op_t next_op;

    // single stage, takes a new command when empty or draining
    assign cmd_ready = !op_valid || op_ready;

    // form the lane operation
    always_comb begin
        next_op.opcode    = cmd.opcode;
        next_op.lane_mask = cmd.lane_mask;
        next_op.lanes     = cmd.lanes;
        case (cmd.opcode)
            op_bind_accumulate: begin
                // bind each lane with the key
                for (int l = 0; l < NUM_LANES; l++) begin
                    next_op.lanes[l] = cmd.lanes[l] ^ cmd.key;
                end
            end
            op_accumulate: begin
                // lanes pass unchanged
            end
            default: begin
                // clear / read carry no lane bits
                next_op.lane_mask = '0;
            end
        endcase
    end

    // stage valid
    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (cmd_ready) begin
            op_valid <= cmd_valid;
        end
    end

    // payload, loads only on a transfer
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op <= next_op;
        end
    end

endmodule

`default_nettype wire

//--- logic/bundle_counters.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_counters
    import hdc_dim_pkg::*, hdc_cmd_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // decoded ops in
    input  wire logic    op_valid,
    output logic         op_ready,
    input  hdc_op_t      op,

    // read results out
    output logic         rd_valid,
    input  wire logic    rd_ready,
    output hdc_result_t  rd
);

    // one counter per dimension
    count_t cnt [DIM];
    count_t cnt_next [DIM];
    tally_t tally;
    tally_t lane_count;
    logic   is_read;
    logic   op_fire;

    assign is_read = (op.opcode == op_read);

    // reads wait for the result stage, everything else goes at once
    assign op_ready = is_read ? rd_ready : 1'b1;
    assign op_fire  = op_valid && op_ready;

    // read hands over the state of all earlier ops
    assign rd_valid = op_valid && is_read;
    assign rd.tally = tally;

    // sign is strictly positive, tie gives 0
    always_comb begin
        for (int d = 0; d < DIM; d++) begin
            rd.sign[d] = (cnt[d] > 0);
        end
    end

    // vectors added by this op
    assign lane_count = tally_t'($countones(op.lane_mask));

    // all masked lanes in one step, then clamp
    always_comb begin
        sum_t sum;
        for (int d = 0; d < DIM; d++) begin
            sum = sum_t'(cnt[d]);
            for (int l = 0; l < NUM_LANES; l++) begin
                if (op.lane_mask[l]) begin
                    // 1 votes up, 0 votes down
                    sum = op.lanes[l][d] ? sum + sum_t'(1) : sum - sum_t'(1);
                end
            end
            if (sum > sum_t'(CNT_MAX)) begin
                cnt_next[d] = count_t'(CNT_MAX);
            end else if (sum < sum_t'(CNT_MIN)) begin
                cnt_next[d] = count_t'(CNT_MIN);
            end else begin
                cnt_next[d] = count_t'(sum);
            end
        end
    end

    // counters and tally
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt   <= '{default: '0};
            tally <= '0;
        end else if (op_fire) begin
            case (op.opcode)
                op_clear: begin
                    cnt   <= '{default: '0};
                    tally <= '0;
                end
                op_accumulate, op_bind_accumulate: begin
                    cnt   <= cnt_next;
                    // tally wraps
                    tally <= tally + lane_count;
                end
                default: begin
                    // read leaves state alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/sign_result.sv
`timescale 1ns/1ps
`default_nettype none

module sign_result
    import hdc_cmd_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // from the counters
    input  wire logic    rd_valid,
    output logic         rd_ready,
    input  hdc_result_t  rd,

    // result port
    output logic         result_valid,
    input  wire logic    result_ready,
    output hdc_result_t  result
);

    logic load;

    // free when empty or the held entry leaves this edge
    assign rd_ready = !result_valid || result_ready;
    assign load     = rd_valid && rd_ready;

    // entry valid
    // a new load may replace an entry on the edge it drains
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (rd_ready) begin
            result_valid <= rd_valid;
        end
    end

    // held data, only changes on a load
    // stable while stalled since rd_ready is low then
    always_ff @(posedge clk) begin
        if (load) begin
            result <= rd;
        end
    end

endmodule

`default_nettype wire

//--- logic/hdc_bundler_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_top
    import hdc_dim_pkg::*, hdc_cmd_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,

    // command stream
    input  wire logic    cmd_valid,
    output logic         cmd_ready,
    input  hdc_cmd_t     cmd,

    // result stream
    output logic         result_valid,
    input  wire logic    result_ready,
    output hdc_result_t  result
);

    // decode to execute
    logic         op_valid;
    logic         op_ready;
    hdc_op_t      op;

    // execute to result
    logic         rd_valid;
    logic         rd_ready;
    hdc_result_t  rd;

    // registers commands, binds keys
    cmd_decode u_cmd_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op)
    );

    // counter array and tally
    bundle_counters u_bundle_counters (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op       (op),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd       (rd)
    );

    // one-entry output buffer
    sign_result u_sign_result (
        .clk          (clk),
        .reset        (reset),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd           (rd),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- bench/hdc_bundler_sva.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_sva
    import hdc_cmd_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire logic    rd_valid,
    input  hdc_result_t  rd,
    input  wire logic    result_valid,
    input  wire logic    result_ready,
    input  hdc_result_t  result
);

    // entry empty once reset has been seen
    a_empty_after_reset: assert property (@(posedge clk) reset |=> !result_valid)
        else $error("result_valid high in the cycle after reset");

    // held entry frozen under back-pressure
    a_stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result valid or data changed while result_ready was low");

    // full and not draining so a waiting read stays put upstream
    a_read_held_when_full: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready && rd_valid |=> rd_valid && $stable(rd))
        else $error("waiting read changed or dropped while the entry was full");

endmodule

// attach to every result stage
bind sign_result hdc_bundler_sva u_sva (.*);

`default_nettype wire

//--- bench/hdc_bundler_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_tb
    import hdc_dim_pkg::*, hdc_cmd_pkg::*;
;

    localparam logic [31:0] SEED = 32'h9552dec9;
    localparam int NUM_ENTRIES = 25;
    localparam int TIMEOUT     = 200;
    // counters clamp symmetrically at +-127
    localparam int SAT         = 127;
    localparam logic [1:0] KEY_ZERO    = 2'd0;
    localparam logic [1:0] KEY_RANDOM  = 2'd1;
    localparam logic [1:0] KEY_ONES    = 2'd2;
    localparam logic [1:0] LANE_RANDOM = 2'd0;
    localparam logic [1:0] LANE_SAME   = 2'd1;
    localparam logic [1:0] LANE_INVERT = 2'd2;

    typedef struct packed {
        opcode_t                op;
        logic [NUM_LANES-1:0]   mask;
        logic [1:0]             key_sel;
        logic [1:0]             lane_src;
        logic [7:0]             reps;
        logic [3:0]             stall;
    } entry_t;

    // opcode, mask, key, lanes, repeats, result_ready stall cycles
    localparam entry_t STIM [NUM_ENTRIES] = '{
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd2},
        '{op_clear,           4'b1010, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0101, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_accumulate,      4'b0111, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd3},
        '{op_clear,           4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_accumulate,      4'b1011, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_accumulate,      4'b1100, KEY_RANDOM, LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd1},
        '{op_clear,           4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_bind_accumulate, 4'b0111, KEY_RANDOM, LANE_RANDOM, 8'd1,  4'd0},
        '{op_bind_accumulate, 4'b0010, KEY_ONES,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd2},
        '{op_accumulate,      4'b0011, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_clear,           4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_accumulate,      4'b1111, KEY_ZERO,   LANE_SAME,   8'd40, 4'd0},
        '{op_accumulate,      4'b0001, KEY_ZERO,   LANE_INVERT, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd4},
        '{op_accumulate,      4'b0111, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd5},
        '{op_accumulate,      4'b0001, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_clear,           4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0},
        '{op_read,            4'b0000, KEY_ZERO,   LANE_RANDOM, 8'd1,  4'd0}
    };

    logic         clk = 1'b0;
    logic         reset;
    logic         cmd_valid;
    logic         cmd_ready;
    hdc_cmd_t     cmd;
    logic         result_valid;
    logic         result_ready = 1'b1;
    hdc_result_t  result;

    // reference model of the counters and tally
    int           model_cnt [DIM];
    tally_t       model_tally;
    hdc_result_t  exp_q [$];
    int           stall_q [$];
    hv_t          base_hv;

    // monitor state
    hdc_result_t  held;
    hdc_result_t  expd;
    logic         seen = 1'b0;
    int           hold = 0;

    int   mismatch_errors = 0;
    int   stability_errors = 0;
    int   protocol_errors = 0;
    int   timeout_errors = 0;
    int   cmd_count = 0;
    logic timed_out = 1'b0;

    hdc_bundler_top dut (.*);

    always #4 clk = ~clk;

    function automatic hv_t random_hv();
        return {$urandom, $urandom};
    endfunction

    // majority counters that saturate after all lanes of one command
    task automatic model_apply(input hdc_cmd_t c);
        int sum;
        hv_t v;
        hdc_result_t e;
        case (c.opcode)
            op_clear: begin
                model_cnt = '{default: 0};
                model_tally = '0;
            end
            op_read: begin
                // tie stays 0
                for (int d = 0; d < DIM; d++) begin
                    e.sign[d] = (model_cnt[d] > 0);
                end
                e.tally = model_tally;
                exp_q.push_back(e);
            end
            default: begin
                for (int d = 0; d < DIM; d++) begin
                    sum = model_cnt[d];
                    for (int l = 0; l < NUM_LANES; l++) begin
                        if (c.lane_mask[l]) begin
                            v = (c.opcode == op_bind_accumulate) ? c.lanes[l] ^ c.key : c.lanes[l];
                            sum += v[d] ? 1 : -1;
                        end
                    end
                    model_cnt[d] = (sum > SAT) ? SAT : ((sum < -SAT) ? -SAT : sum);
                end
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (c.lane_mask[l]) begin
                        model_tally++;
                    end
                end
            end
        endcase
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_cmd(input hdc_cmd_t c);
        int waited;
        waited = 0;
        cmd = c;
        cmd_valid = 1'b1;
        #1;
        while (!cmd_ready && !timed_out) begin
            @(negedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: command %0d was never accepted", cmd_count);
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_count++;
    endtask

    task automatic apply_entry(input entry_t e);
        hdc_cmd_t c;
        c.opcode = e.op;
        c.lane_mask = e.mask;
        case (e.key_sel)
            KEY_RANDOM: c.key = random_hv();
            KEY_ONES:   c.key = '1;
            default:    c.key = '0;
        endcase
        if (e.lane_src == LANE_SAME) begin
            base_hv = random_hv();
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (e.lane_src == LANE_SAME) begin
                c.lanes[l] = base_hv;
            end else if (e.lane_src == LANE_INVERT) begin
                c.lanes[l] = ~base_hv;
            end else begin
                c.lanes[l] = random_hv();
            end
        end
        if (e.op == op_read) begin
            stall_q.push_back(int'(e.stall));
        end
        for (int r = 0; r < int'(e.reps) && !timed_out; r++) begin
            model_apply(c);
            send_cmd(c);
        end
    endtask

    // result sink that checks each result and stalls it as the table asks
    always @(negedge clk) begin
        if (reset || !result_valid) begin
            result_ready = 1'b1;
            seen = 1'b0;
        end else begin
            if (!seen) begin
                seen = 1'b1;
                held = result;
                hold = 0;
                if (exp_q.size() == 0) begin
                    $display("unexpected result at %0t with no read outstanding", $time);
                    protocol_errors++;
                end else begin
                    expd = exp_q.pop_front();
                    hold = stall_q.pop_front();
                    if (result !== expd) begin
                        $display("ERROR %0t: result sign %h tally %0d, expected sign %h tally %0d",
                                 $time, result.sign, result.tally, expd.sign, expd.tally);
                        mismatch_errors++;
                    end
                end
            end else if (result !== held) begin
                $display("ERROR %0t: result changed while stalled", $time);
                stability_errors++;
                held = result;
            end
            // transfer on the next rising edge once the stall runs out
            if (hold > 0) begin
                result_ready = 1'b0;
                hold--;
            end else begin
                result_ready = 1'b1;
                seen = 1'b0;
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(SEED));
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        model_cnt = '{default: 0};
        model_tally = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NUM_ENTRIES && !timed_out; i++) begin
            apply_entry(STIM[i]);
        end

        // wait for outstanding reads
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: %0d results never arrived", exp_q.size());
                timeout_errors++;
                timed_out = 1'b1;
            end
        end
        repeat (4) @(negedge clk);

        $display("errors: %0d mismatch, %0d stability, %0d protocol, %0d timeout",
                 mismatch_errors, stability_errors, protocol_errors, timeout_errors);
        if (mismatch_errors + stability_errors + protocol_errors + timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/hdc_dim_pkg.sv
logic/hdc_cmd_pkg.sv
logic/cmd_decode.sv
logic/bundle_counters.sv
logic/sign_result.sv
logic/hdc_bundler_top.sv
bench/hdc_bundler_sva.sv
bench/hdc_bundler_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := hdc_bundler_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	-$(OBJ_DIR)/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
